//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = usb_dma_rx_tb
FILELIST = usb_dma_rx.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/usb_dma_rx_tb.sv
module usb_dma_rx_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import usb_pkg::*;

    localparam int clock_div = 2;
    localparam int fifo_depth = 8;
    localparam int addr_width = 32;

    typedef enum {
        until_drained,
        until_backlog,
        until_link_busy,
        until_link_idle
    } wait_cond_e;

    logic sys;
    logic reset;
    logic usb_clk;
    logic usb_cs;
    logic usb_miso;
    wire [3:0] usb_miosi;
    logic usb_pwren;
    logic rx_flush;
    logic dma_request;
    logic dma_write;
    logic [addr_width-1:0] dma_address;
    logic [15:0] dma_wdata;
    logic dma_ack;

    integer seed;
    int error_count;
    int tests_run;
    int tests_failed;
    int test_start_errors;
    bit timed_out;
    int words_before;
    int txns_before;
    int naks_before;

    // chip model, bytes it acked but memory has not seen yet
    logic [7:0] exp_q[$];
    int allowance;
    int txn_count;
    int nak_count;
    int rise_count;
    logic clk_seen;
    logic chip_drive;
    logic [3:0] chip_nibble;
    logic [7:0] chip_byte;
    logic [31:0] chip_rand;

    // memory model
    bit ack_enable;
    int ack_wait;
    int word_count;
    logic [15:0] want_word;

    usb_dma_rx #(
        .CLOCK_DIV(clock_div),
        .FIFO_DEPTH(fifo_depth),
        .ADDR_WIDTH(addr_width)
    ) usb_dma_rx_i (
        .sys(sys),
        .reset(reset),
        .usb_clk(usb_clk),
        .usb_cs(usb_cs),
        .usb_miso(usb_miso),
        .usb_miosi(usb_miosi),
        .usb_pwren(usb_pwren),
        .rx_flush(rx_flush),
        .dma_request(dma_request),
        .dma_write(dma_write),
        .dma_address(dma_address),
        .dma_wdata(dma_wdata),
        .dma_ack(dma_ack)
    );

    // chip side of the shared bus
    assign usb_miosi = chip_drive ? chip_nibble : 4'bzzzz;

    initial begin
        sys = 1'b0;
        forever #10 sys = ~sys;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            $display("Error: %s is %h, expected %h", name, got, want);
            error_count++;
        end
    endtask

    function automatic bit cond_met(input wait_cond_e c);
        case (c)
            until_drained: return allowance == 0 && exp_q.size() == 0 && !dma_request;
            until_backlog: return exp_q.size() >= fifo_depth + 2;
            until_link_busy: return !usb_cs;
            default: return usb_cs;
        endcase
    endfunction

    task automatic wait_until(input wait_cond_e c, input int limit);
        int n;
        n = 0;
        while (!cond_met(c) && n < limit) begin
            @(negedge sys);
            n++;
        end
        if (!cond_met(c)) begin
            $display("timeout after %0d cycles waiting for %s", limit, c.name());
            timed_out = 1'b1;
        end
    endtask

    task automatic start_test();
        test_start_errors = error_count;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (error_count == test_start_errors) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end
    endtask

    // fill until the fifo is full behind one pending word
    task automatic fill_backlog(input int bytes);
        ack_enable = 1'b0;
        allowance = bytes;
        wait_until(until_backlog, 5000);
        if (timed_out) return;
        // last acked byte still crosses the link
        repeat (40) @(negedge sys);
        assert (exp_q.size() == fifo_depth + 2) else begin
            $display("backlog holds %0d bytes instead of %0d", exp_q.size(), fifo_depth + 2);
            error_count++;
        end
    endtask

    // chip model, follows usb_clk edges as seen on the falling sys edge
    always @(negedge sys) begin
        if (reset || usb_cs) begin
            chip_drive = 1'b0;
            usb_miso = 1'b1;
            rise_count = 0;
        end else if (usb_clk && !clk_seen) begin
            rise_count++;
            if (rise_count == 1) begin
                txn_count++;
                check_value("usb_miosi", usb_miosi, ft_cmd_read[7:4]);
            end else if (rise_count == 2) begin
                check_value("usb_miosi", usb_miosi, ft_cmd_read[3:0]);
            end else if (rise_count >= 4) begin
                // any dut drive here would corrupt the chip nibble
                check_value("usb_miosi", usb_miosi, chip_nibble);
            end
        end else if (!usb_clk && clk_seen) begin
            if (rise_count == 3) begin
                chip_rand = $random(seed);
                chip_byte = chip_rand[15:8];
                // roughly one in four transactions is a nak
                if (allowance > 0 && chip_rand[1:0] != 2'b00) begin
                    usb_miso = 1'b0;
                    exp_q.push_back(chip_byte);
                    allowance--;
                end else begin
                    usb_miso = 1'b1;
                    nak_count++;
                end
                chip_drive = 1'b1;
                chip_nibble = chip_byte[7:4];
            end else if (rise_count == 4) begin
                chip_nibble = chip_byte[3:0];
            end
        end
        clk_seen = usb_clk;
    end

    // memory model, acks after 0 to 5 cycles
    always @(negedge sys) begin
        if (reset) begin
            dma_ack = 1'b0;
            ack_wait = 0;
        end else if (dma_ack) begin
            dma_ack = 1'b0;
            ack_wait = {$random(seed)} % 6;
        end else if (dma_request && ack_enable) begin
            if (ack_wait > 0) begin
                ack_wait--;
            end else begin
                assert (exp_q.size() >= 2) else begin
                    $display("DMA word written with fewer than two acked bytes left");
                    error_count++;
                end
                if (exp_q.size() >= 2) begin
                    // first byte of the pair goes high
                    want_word = {exp_q[0], exp_q[1]};
                    void'(exp_q.pop_front());
                    void'(exp_q.pop_front());
                    check_value("dma_wdata", dma_wdata, want_word);
                end
                check_value("dma_address", dma_address, word_count * 2);
                check_value("dma_write", dma_write, 1);
                word_count++;
                dma_ack = 1'b1;
            end
        end
    end

    initial begin
        seed = 32'h7b7f;
        reset = 1'b1;
        usb_miso = 1'b1;
        usb_pwren = 1'b1;
        rx_flush = 1'b0;
        dma_ack = 1'b0;
        chip_drive = 1'b0;
        chip_nibble = 4'h0;
        clk_seen = 1'b0;
        ack_enable = 1'b1;
        repeat (10) @(negedge sys);
        reset = 1'b0;

        // device still unconfigured, link must stay quiet
        start_test();
        repeat (20) @(negedge sys);
        check_value("usb_cs", usb_cs, 1);
        check_value("usb_clk", usb_clk, 0);
        check_value("dma_request", dma_request, 0);
        check_value("dma_address", dma_address, 0);
        end_test("reset state");

        // nibble and bus release checks run in the chip model
        start_test();
        usb_pwren = 1'b0;
        allowance = 20;
        wait_until(until_drained, 5000);
        if (!timed_out) begin
            end_test("link command nibbles");
        end

        if (!timed_out) begin
            start_test();
            words_before = word_count;
            naks_before = nak_count;
            allowance = 200;
            wait_until(until_drained, 20000);
        end
        if (!timed_out) begin
            check_value("word count", word_count - words_before, 100);
            assert (nak_count > naks_before) else begin
                $display("no NAK transaction was mixed into the random stream");
                error_count++;
            end
            end_test("200 random bytes");
        end

        if (!timed_out) begin
            start_test();
            fill_backlog(40);
        end
        if (!timed_out) begin
            txns_before = txn_count;
            repeat (200) @(negedge sys);
            assert (txn_count == txns_before) else begin
                $display("link transaction started while the FIFO was full");
                error_count++;
            end
            ack_enable = 1'b1;
            wait_until(until_drained, 10000);
        end
        if (!timed_out) begin
            end_test("back-pressure");
        end

        if (!timed_out) begin
            start_test();
            words_before = word_count;
            fill_backlog(50);
        end
        if (!timed_out) begin
            rx_flush = 1'b1;
            // keep the pending word, drop what sat in the fifo
            while (exp_q.size() > 2) begin
                void'(exp_q.pop_back());
            end
            @(negedge sys);
            rx_flush = 1'b0;
            ack_enable = 1'b1;
            wait_until(until_drained, 10000);
        end
        if (!timed_out) begin
            check_value("word count", word_count - words_before, 21);
            end_test("flush");
        end

        if (!timed_out) begin
            start_test();
            allowance = 1000;
            wait_until(until_link_busy, 500);
        end
        if (!timed_out) begin
            // current transaction must still finish
            usb_pwren = 1'b1;
            wait_until(until_link_idle, 500);
        end
        if (!timed_out) begin
            txns_before = txn_count;
            repeat (200) @(negedge sys);
            assert (txn_count == txns_before) else begin
                $display("link transaction started with usb_pwren high");
                error_count++;
            end
            allowance = 0;
            end_test("usb_pwren stop");
        end

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (timed_out || error_count != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

//--- usb_dma_rx.f
verilog/usb_pkg.sv
verilog/dma_pkg.sv
verilog/byte_stream_if.sv
verilog/ft1248_reader.sv
verilog/rx_fifo.sv
verilog/dma_word_packer.sv
verilog/usb_dma_rx.sv
testbench/usb_dma_rx_tb.sv

//--- verilog/byte_stream_if.sv
interface byte_stream_if;

    // head byte is valid while empty is low
    logic empty;
    logic [7:0] rdata;

    // single cycle pulses
    logic read;
    logic flush;

    // buffer side, presents the head byte
    modport fifo (
        output empty,
        output rdata,
        input read,
        input flush
    );

    // consumer side, pops bytes and sees flushes
    modport sink (
        input empty,
        input rdata,
        input flush,
        output read
    );

endinterface

//--- verilog/dma_pkg.sv
package dma_pkg;

    // width of one memory word
    localparam int dma_word_width = 16;

    // one word as written to memory
    // first received byte sits in the upper half
    typedef logic [dma_word_width-1:0] dma_word_t;

    // byte address step per word
    localparam int dma_word_bytes = dma_word_width / 8;

endpackage

//--- verilog/dma_word_packer.sv
module dma_word_packer #(
    parameter int ADDR_WIDTH = 32
) (
    input logic sys,
    input logic reset,

    byte_stream_if.sink src,

    output logic dma_request,
    output logic dma_write,
    output logic [ADDR_WIDTH-1:0] dma_address,
    output dma_pkg::dma_word_t dma_wdata,
    input logic dma_ack
);

    import dma_pkg::*;

    typedef enum logic {
        s_idle,
        s_wait
    } state_e;

    state_e state;

    // high once the upper byte of a word is taken
    logic byte_toggle;

    // receive path only ever writes
    assign dma_write = 1'b1;

    always_ff @(posedge sys) begin
        src.read <= 1'b0;

        if (reset) begin
            state <= s_idle;
            byte_toggle <= 1'b0;
            dma_request <= 1'b0;
            dma_address <= '0;
        end else begin
            case (state)
                s_idle: begin
                    // fifo pops on the read edge, so skip the cycle after
                    // head byte is gone once a flush lands
                    if (!src.empty && !src.read && !src.flush) begin
                        src.read <= 1'b1;
                        byte_toggle <= ~byte_toggle;
                        // first byte ends up in the upper half
                        dma_wdata <= {dma_wdata[7:0], src.rdata};
                        if (byte_toggle) begin
                            dma_request <= 1'b1;
                            state <= s_wait;
                        end
                    end
                end

                s_wait: begin
                    // word held steady until memory takes it
                    if (dma_ack) begin
                        dma_request <= 1'b0;
                        dma_address <= dma_address + ADDR_WIDTH'(dma_word_bytes);
                        state <= s_idle;
                    end
                end

                default: begin
                    state <= s_idle;
                end
            endcase

            // flushed bytes never pair with later ones
            if (src.flush) begin
                byte_toggle <= 1'b0;
            end
        end
    end

    // memory side may sample any cycle while the request waits
    assert property (@(posedge sys) disable iff (reset)
        dma_request && !dma_ack |=>
            dma_request && $stable(dma_address) && $stable(dma_wdata))
        else $error("dma port changed before dma_ack");

endmodule

//--- verilog/ft1248_reader.sv
module ft1248_reader #(
    parameter int CLOCK_DIV = 2
) (
    input logic sys,
    input logic reset,

    output logic usb_clk,
    output logic usb_cs,
    input logic usb_miso,
    inout wire [3:0] usb_miosi,
    input logic usb_pwren,

    input logic fifo_full,
    output logic fifo_write,
    output logic [7:0] fifo_wdata
);

    import usb_pkg::*;

    localparam int div_width = (CLOCK_DIV > 1) ? $clog2(CLOCK_DIV) : 1;

    logic [div_width-1:0] div_count;
    logic half_tick;

    logic [1:0] pwren_sync;

    ft_phase_e phase;
    ft_phase_e next_phase;

    ft_nibble_t data_high;
    logic byte_ack;

    logic drive_en;
    ft_nibble_t drive_nibble;

    // half period timebase for usb_clk
    always_ff @(posedge sys) begin
        if (reset || half_tick) begin
            div_count <= '0;
        end else begin
            div_count <= div_count + 1'b1;
        end
    end

    assign half_tick = (div_count == div_width'(CLOCK_DIV - 1));

    // pwren comes from the chip, async to sys
    // starts as "not configured"
    always_ff @(posedge sys) begin
        if (reset) begin
            pwren_sync <= 2'b11;
        end else begin
            pwren_sync <= {pwren_sync[0], usb_pwren};
        end
    end

    // phase order of one read transaction
    always_comb begin
        case (phase)
            ph_cmd_high: next_phase = ph_cmd_low;
            ph_cmd_low: next_phase = ph_turn;
            ph_turn: next_phase = ph_data_high;
            ph_data_high: next_phase = ph_data_low;
            ph_data_low: next_phase = ph_release;
            default: next_phase = ph_idle;
        endcase
    end

    // each full phase is clk low half then clk high half
    // idle and release last one half period, clock low
    always_ff @(posedge sys) begin
        fifo_write <= 1'b0;

        if (reset) begin
            phase <= ph_idle;
            usb_cs <= 1'b1;
            usb_clk <= 1'b0;
        end else if (half_tick) begin
            case (phase)
                ph_idle: begin
                    // only one byte per transaction, so a free slot is enough
                    if (!pwren_sync[1] && !fifo_full) begin
                        phase <= ph_cmd_high;
                        usb_cs <= 1'b0;
                    end
                end

                ph_release: begin
                    phase <= ph_idle;
                end

                default: begin
                    if (!usb_clk) begin
                        // rising edge, chip data is stable here
                        usb_clk <= 1'b1;
                        if (phase == ph_data_high) begin
                            data_high <= usb_miosi;
                            byte_ack <= (usb_miso == ft_miso_ack);
                        end
                        if (phase == ph_data_low) begin
                            fifo_wdata <= {data_high, usb_miosi};
                            // nak bytes are dropped here
                            fifo_write <= byte_ack;
                        end
                    end else begin
                        usb_clk <= 1'b0;
                        phase <= next_phase;
                        if (phase == ph_data_low) begin
                            usb_cs <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // fpga owns the bus only for the command nibbles
    assign drive_en = (phase == ph_cmd_high) || (phase == ph_cmd_low);
    assign drive_nibble = (phase == ph_cmd_high) ? ft_cmd_read[7:4] : ft_cmd_read[3:0];
    assign usb_miosi = drive_en ? drive_nibble : 4'bzzzz;

    // bus contention guard, cs and drive come from separate state
    assert property (@(posedge sys) disable iff (reset) usb_cs |-> !drive_en)
        else $error("usb_miosi driven while usb_cs is high");

endmodule

//--- verilog/rx_fifo.sv
module rx_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input logic sys,
    input logic reset,

    input logic write,
    input logic [7:0] wdata,
    output logic full,

    byte_stream_if.fifo rd
);

    localparam int ptr_width = $clog2(FIFO_DEPTH);

    logic [7:0] mem [FIFO_DEPTH];

    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width:0] count;

    logic push;
    logic pop;

    assign full = (count == (ptr_width + 1)'(FIFO_DEPTH));

    // first word fall through, head is always on rdata
    assign rd.empty = (count == '0);
    assign rd.rdata = mem[rd_ptr];

    // flush wins over both sides
    assign push = write && !full && !rd.flush;
    assign pop = rd.read && !rd.empty && !rd.flush;

    always_ff @(posedge sys) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge sys) begin
        if (reset || rd.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // reader checks full only at transaction start
    assert property (@(posedge sys) disable iff (reset) write |-> !full)
        else $error("rx_fifo write while full");

    // consumer must look at empty before popping
    assert property (@(posedge sys) disable iff (reset) rd.read |-> !rd.empty)
        else $error("rx_fifo read while empty");

endmodule

//--- verilog/usb_dma_rx.sv
module usb_dma_rx #(
    parameter int CLOCK_DIV = 2,
    parameter int FIFO_DEPTH = 8,
    parameter int ADDR_WIDTH = 32
) (
    input logic sys,
    input logic reset,

    output logic usb_clk,
    output logic usb_cs,
    input logic usb_miso,
    inout wire [3:0] usb_miosi,
    input logic usb_pwren,

    input logic rx_flush,

    output logic dma_request,
    output logic dma_write,
    output logic [ADDR_WIDTH-1:0] dma_address,
    output dma_pkg::dma_word_t dma_wdata,
    input logic dma_ack
);

    // link reader to buffer
    logic fifo_full;
    logic fifo_write;
    logic [7:0] fifo_wdata;

    // buffer to packer
    byte_stream_if rx_stream ();

    assign rx_stream.flush = rx_flush;

    ft1248_reader #(
        .CLOCK_DIV(CLOCK_DIV)
    ) ft1248_reader_i (
        .sys(sys),
        .reset(reset),
        .usb_clk(usb_clk),
        .usb_cs(usb_cs),
        .usb_miso(usb_miso),
        .usb_miosi(usb_miosi),
        .usb_pwren(usb_pwren),
        .fifo_full(fifo_full),
        .fifo_write(fifo_write),
        .fifo_wdata(fifo_wdata)
    );

    rx_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) rx_fifo_i (
        .sys(sys),
        .reset(reset),
        .write(fifo_write),
        .wdata(fifo_wdata),
        .full(fifo_full),
        .rd(rx_stream.fifo)
    );

    dma_word_packer #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) dma_word_packer_i (
        .sys(sys),
        .reset(reset),
        .src(rx_stream.sink),
        .dma_request(dma_request),
        .dma_write(dma_write),
        .dma_address(dma_address),
        .dma_wdata(dma_wdata),
        .dma_ack(dma_ack)
    );

endmodule

//--- verilog/usb_pkg.sv
package usb_pkg;

    // one value on the reduced 4-bit ft1248 bus
    typedef logic [3:0] ft_nibble_t;

    // single byte read command
    // high nibble goes out first
    localparam logic [7:0] ft_cmd_read = 8'h40;

    // miso level at the first data rise
    // low means the chip has a byte for us
    localparam logic ft_miso_ack = 1'b0;

    // reader phases, one usb_clk period each except idle and release
    typedef enum logic [2:0] {
        // cs high, waiting for a start condition
        ph_idle,
        // command nibbles driven by the fpga
        ph_cmd_high,
        ph_cmd_low,
        // bus released, chip takes over
        ph_turn,
        // data nibbles driven by the chip
        ph_data_high,
        ph_data_low,
        // cs back high, clock parked low
        ph_release
    } ft_phase_e;

endpackage
